// ==== warpPkg.sv ====
`default_nettype none

package warpPkg;

	// word address of the FSB, bit 0 is replaced by the data strobes
	typedef logic [23:1] fsbAddr_t;

	// one FSB cycle as seen at the CPU pins, strobes already made active high
	typedef struct packed {
		fsbAddr_t addr;
		logic     write;
		logic     upper;
		logic     lower;
	} fsbCycle_t;

	// device targeted by the current FSB cycle
	typedef enum logic [2:0] {
		selNone,
		selRam,
		selRom,
		selIo,
		selIack
	} devSel_e;

	// one request handed from the I/O slave to the host bus master
	typedef struct packed {
		logic     write;
		logic     upper;
		logic     lower;
		fsbAddr_t addr;
	} ioReq_t;

	// multiplexed DRAM row or column address
	typedef logic [11:0] dramAddr_t;

	// DRAM sequencer states, CPU access first and CBR refresh after
	typedef enum logic [2:0] {
		ramIdle,
		ramRas,
		ramCas,
		ramDone,
		refCas,
		refRas,
		refEnd
	} ramState_e;

	// flash needs this many FCLK cycles from select to data valid
	parameter int DEF_ROM_WAIT = 4;
	// refresh interval in FCLK cycles and the extra slack before it turns urgent
	parameter int DEF_REFRESH_PERIOD = 64;
	parameter int DEF_REFRESH_URGENT = 32;

endpackage

`default_nettype wire

// ==== addrDecode.sv ====
`default_nettype none

module addrDecode (
	input  logic                FCLK,
	input  logic                rst,
	input  warpPkg::fsbCycle_t  fsb,
	input  logic                fcIack,
	input  logic                busActive,
	input  logic                asN,
	output warpPkg::devSel_e    sel
);

	// combinational decode of the live address
	warpPkg::devSel_e selNext;
	// set once the select for this cycle has been captured
	logic latched;

	always_comb begin
		// interrupt acknowledge space overrides the address map
		if (fcIack) begin
			selNext = warpPkg::selIack;
		end else if (fsb.addr[23:22] == 2'b00) begin
			// lower 4 MB of DRAM
			selNext = warpPkg::selRam;
		end else if (fsb.addr[23:20] == 4'h4) begin
			selNext = warpPkg::selRom;
		end else if (fsb.addr[23:20] == 4'h5 || fsb.addr[23:22] == 2'b11) begin
			// $5xxxxx and $Cxxxxx to $Fxxxxx go out to the host bus
			selNext = warpPkg::selIo;
		end else begin
			selNext = warpPkg::selNone;
		end
	end

	always_ff @(posedge FCLK) begin
		if (rst) begin
			sel     <= warpPkg::selNone;
			latched <= 1'b0;
		end else if (asN) begin
			// AS released, drop the select so the next cycle starts clean
			sel     <= warpPkg::selNone;
			latched <= 1'b0;
		end else if (busActive && !latched) begin
			// first cycle of busActive, the address is known stable here
			sel     <= selNext;
			latched <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== refreshTimer.sv ====
`default_nettype none

module refreshTimer #(
	parameter int REFRESH_PERIOD = warpPkg::DEF_REFRESH_PERIOD,
	parameter int REFRESH_URGENT = warpPkg::DEF_REFRESH_URGENT
) (
	input  logic FCLK,
	input  logic rst,
	input  logic refAck,
	output logic refReq,
	output logic refUrg
);

	localparam int TOTAL = REFRESH_PERIOD + REFRESH_URGENT;
	localparam int CW = $clog2(TOTAL);

	// cycles since the last refresh, stops at the urgent threshold
	logic [CW-1:0] cnt;

	always_ff @(posedge FCLK) begin
		if (rst || refAck) begin
			// a started refresh satisfies both flags and restarts the interval
			cnt    <= '0;
			refReq <= 1'b0;
			refUrg <= 1'b0;
		end else begin
			if (cnt != CW'(TOTAL - 1)) begin
				cnt <= cnt + 1'b1;
			end
			// flags are sticky until the RAM controller acknowledges
			if (cnt == CW'(REFRESH_PERIOD - 1)) begin
				refReq <= 1'b1;
			end
			if (cnt == CW'(TOTAL - 1)) begin
				refUrg <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ramCtrl.sv ====
`default_nettype none

module ramCtrl (
	input  logic                FCLK,
	input  logic                rst,
	input  warpPkg::fsbCycle_t  fsb,
	input  warpPkg::devSel_e    sel,
	input  logic                busActive,
	input  logic                asN,
	input  logic                refReq,
	input  logic                refUrg,
	output logic                ramReady,
	output logic                refAck,
	output warpPkg::dramAddr_t  ra,
	output logic                rasN,
	output logic                casN,
	output logic                lweN,
	output logic                uweN,
	output logic                oeN,
	output logic                romOeN
);

	warpPkg::ramState_e state;
	// second half of the two cycle RAS pulse during refresh
	logic refPhase;
	// CPU is waiting on a DRAM access
	logic cpuRam;
	// column address is on RA and CAS is low for a CPU access
	logic colOn;

	assign cpuRam = busActive && (sel == warpPkg::selRam);
	assign colOn = (state == warpPkg::ramCas) || (state == warpPkg::ramDone);

	always_ff @(posedge FCLK) begin
		if (rst) begin
			state    <= warpPkg::ramIdle;
			refPhase <= 1'b0;
			refAck   <= 1'b0;
		end else begin
			refAck <= 1'b0;
			unique case (state)
				warpPkg::ramIdle: begin
					// urgent refresh wins over the CPU, a plain request waits for an idle bus
					if (refUrg || (refReq && !busActive)) begin
						state  <= warpPkg::refCas;
						refAck <= 1'b1;
					end else if (cpuRam) begin
						state <= warpPkg::ramRas;
					end
				end
				warpPkg::ramRas:  state <= warpPkg::ramCas;
				warpPkg::ramCas:  state <= warpPkg::ramDone;
				warpPkg::ramDone: begin
					// hold the row open until the CPU ends the cycle
					if (asN) begin
						state <= warpPkg::ramIdle;
					end
				end
				warpPkg::refCas: begin
					refPhase <= 1'b0;
					state    <= warpPkg::refRas;
				end
				warpPkg::refRas: begin
					if (refPhase) begin
						state <= warpPkg::refEnd;
					end
					refPhase <= 1'b1;
				end
				// precharge cycle with both strobes high
				warpPkg::refEnd:  state <= warpPkg::ramIdle;
				default:          state <= warpPkg::ramIdle;
			endcase
		end
	end

	always_comb begin
		ramReady = (state == warpPkg::ramDone);
		// RAS covers the CPU access and both refresh RAS cycles
		rasN = !((state == warpPkg::ramRas) || colOn || (state == warpPkg::refRas));
		// CAS stays low while RAS falls so the DRAM sees CAS before RAS
		casN = !(colOn || (state == warpPkg::refCas) || (state == warpPkg::refRas));
		// write enables are per byte lane and only while the column is strobed
		lweN = !(colOn && fsb.write && fsb.lower);
		uweN = !(colOn && fsb.write && fsb.upper);
		oeN  = !(colOn && !fsb.write);
		// the flash drives data for the whole of a ROM read
		romOeN = !(busActive && (sel == warpPkg::selRom) && !fsb.write);
		// row is A21..A12 and column is A11..A1, both zero padded to 12 bits
		if (colOn) begin
			ra = {1'b0, fsb.addr[11:1]};
		end else begin
			ra = {2'b00, fsb.addr[21:12]};
		end
	end

endmodule

`default_nettype wire

// ==== ioBusSlave.sv ====
`default_nettype none

module ioBusSlave (
	input  logic                FCLK,
	input  logic                rst,
	input  warpPkg::fsbCycle_t  fsb,
	input  warpPkg::devSel_e    sel,
	input  logic                busActive,
	input  logic                asN,
	input  logic                ioBusy,
	input  logic                ioDone,
	input  logic                ioErr,
	output warpPkg::ioReq_t     ioReq,
	output logic                ioStart,
	output logic                ioReady,
	output logic                ioFault
);

	// this FSB cycle already produced its host request
	logic served;
	// a read is out on the host bus and the CPU waits for it
	logic rdPend;
	// FSB I/O cycle that can be handed to the master now
	logic issue;

	assign issue = busActive && (sel == warpPkg::selIo) && !served && !ioBusy;

	always_ff @(posedge FCLK) begin
		if (rst) begin
			served  <= 1'b0;
			rdPend  <= 1'b0;
			ioStart <= 1'b0;
			ioReady <= 1'b0;
			ioFault <= 1'b0;
		end else begin
			ioStart <= issue && !asN;
			if (asN) begin
				// cycle over, get ready for the next one
				served  <= 1'b0;
				ioReady <= 1'b0;
				ioFault <= 1'b0;
			end else begin
				if (issue) begin
					served  <= 1'b1;
					// posted write, the CPU is released before the host answers
					ioReady <= fsb.write;
				end
				if (rdPend && ioDone) begin
					ioReady <= 1'b1;
				end
				if (rdPend && ioErr) begin
					ioFault <= 1'b1;
				end
			end
			// a posted write never sets rdPend, so its bus error is lost
			if (issue && !asN) begin
				rdPend <= !fsb.write;
			end else if (ioDone || ioErr) begin
				rdPend <= 1'b0;
			end
		end
	end

	// request payload, only meaningful together with ioStart
	always_ff @(posedge FCLK) begin
		if (issue) begin
			ioReq <= '{write: fsb.write, upper: fsb.upper, lower: fsb.lower, addr: fsb.addr};
		end
	end

endmodule

`default_nettype wire

// ==== ioBusMaster.sv ====
`default_nettype none

module ioBusMaster (
	input  logic               FCLK,
	input  logic               rst,
	input  warpPkg::ioReq_t    ioReq,
	input  logic               ioStart,
	input  logic               hostDtackN,
	input  logic               hostBerrN,
	output warpPkg::fsbAddr_t  hostAddr,
	output logic               hostAsN,
	output logic               hostUdsN,
	output logic               hostLdsN,
	output logic               ioBusy,
	output logic               ioDone,
	output logic               ioErr
);

	// host cycle phases: address setup, strobes low, completion report
	typedef enum logic [1:0] {
		mIdle,
		mAddr,
		mWait,
		mEnd
	} mState_e;

	mState_e state;
	// byte lanes of the latched request
	logic upperR;
	logic lowerR;
	// host ended the cycle with a bus error
	logic errR;

	assign ioBusy = (state != mIdle);

	always_ff @(posedge FCLK) begin
		if (rst) begin
			state    <= mIdle;
			hostAsN  <= 1'b1;
			hostUdsN <= 1'b1;
			hostLdsN <= 1'b1;
			ioDone   <= 1'b0;
			ioErr    <= 1'b0;
		end else begin
			ioDone <= 1'b0;
			ioErr  <= 1'b0;
			unique case (state)
				mIdle: begin
					if (ioStart) begin
						state <= mAddr;
					end
				end
				mAddr: begin
					// address has had one cycle of setup, drop AS with the lanes
					hostAsN  <= 1'b0;
					hostUdsN <= !upperR;
					hostLdsN <= !lowerR;
					state    <= mWait;
				end
				mWait: begin
					// no timeout here, a slow host device simply stretches the cycle
					if (!hostDtackN || !hostBerrN) begin
						hostAsN  <= 1'b1;
						hostUdsN <= 1'b1;
						hostLdsN <= 1'b1;
						state    <= mEnd;
					end
				end
				mEnd: begin
					ioDone <= !errR;
					ioErr  <= errR;
					state  <= mIdle;
				end
				default: state <= mIdle;
			endcase
		end
	end

	always_ff @(posedge FCLK) begin
		if (state == mIdle && ioStart) begin
			hostAddr <= ioReq.addr;
			upperR   <= ioReq.upper;
			lowerR   <= ioReq.lower;
		end
		// BERR takes priority when the host asserts both
		if (state == mWait) begin
			errR <= !hostBerrN;
		end
	end

endmodule

`default_nettype wire

// ==== cycleTerm.sv ====
`default_nettype none

module cycleTerm #(
	parameter int ROM_WAIT = warpPkg::DEF_ROM_WAIT
) (
	input  logic              FCLK,
	input  logic              rst,
	input  logic              asN,
	input  warpPkg::devSel_e  sel,
	input  logic              ramReady,
	input  logic              ioReady,
	input  logic              ioFault,
	output logic              busActive,
	output logic              busActiveR,
	output logic              dtackN,
	output logic              vpaN,
	output logic              berrN
);

	localparam int CW = $clog2(ROM_WAIT + 1);

	// cycles elapsed since the ROM select became valid
	logic [CW-1:0] romCnt;
	logic romDone;
	// sel is only valid from the second cycle of busActive on
	logic selValid;

	assign selValid = busActive && busActiveR;
	assign romDone = (romCnt == CW'(ROM_WAIT));

	always_ff @(posedge FCLK) begin
		if (rst) begin
			busActive  <= 1'b0;
			busActiveR <= 1'b0;
			romCnt     <= '0;
		end else begin
			busActive  <= !asN;
			busActiveR <= busActive;
			if (!selValid) begin
				romCnt <= '0;
			end else if (sel == warpPkg::selRom && !romDone) begin
				romCnt <= romCnt + 1'b1;
			end
		end
	end

	always_comb begin
		dtackN = 1'b1;
		vpaN   = 1'b1;
		berrN  = 1'b1;
		if (selValid) begin
			unique case (sel)
				warpPkg::selRam:  dtackN = !ramReady;
				// writes to flash are dropped but still get a DTACK
				warpPkg::selRom:  dtackN = !romDone;
				warpPkg::selIo: begin
					dtackN = !ioReady;
					berrN  = !ioFault;
				end
				// autovectored interrupt acknowledge
				warpPkg::selIack: vpaN = 1'b0;
				// unmapped space
				default:          berrN = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== warpSE.sv ====
`default_nettype none

module warpSE #(
	parameter int ROM_WAIT       = warpPkg::DEF_ROM_WAIT,
	parameter int REFRESH_PERIOD = warpPkg::DEF_REFRESH_PERIOD,
	parameter int REFRESH_URGENT = warpPkg::DEF_REFRESH_URGENT
) (
	input  logic               FCLK,
	input  logic               rst,
	// CPU side of the FSB
	input  warpPkg::fsbAddr_t  addr,
	input  logic               asN,
	input  logic               udsN,
	input  logic               ldsN,
	input  logic               weN,
	input  logic               fcIack,
	output logic               dtackN,
	output logic               vpaN,
	output logic               berrN,
	// DRAM and flash
	output warpPkg::dramAddr_t ra,
	output logic               rasN,
	output logic               casN,
	output logic               lweN,
	output logic               uweN,
	output logic               oeN,
	output logic               romOeN,
	// host I/O bus
	output warpPkg::fsbAddr_t  hostAddr,
	output logic               hostAsN,
	output logic               hostUdsN,
	output logic               hostLdsN,
	input  logic               hostDtackN,
	input  logic               hostBerrN
);

	warpPkg::fsbCycle_t fsb;
	warpPkg::devSel_e   sel;
	warpPkg::ioReq_t    ioReq;
	logic busActive;
	logic refReq;
	logic refUrg;
	logic refAck;
	logic ramReady;
	logic ioStart;
	logic ioReady;
	logic ioFault;
	logic ioBusy;
	logic ioDone;
	logic ioErr;

	// pin strobes are active low, the cycle struct carries them active high
	assign fsb = '{addr: addr, write: !weN, upper: !udsN, lower: !ldsN};

	cycleTerm #(.ROM_WAIT(ROM_WAIT)) i_cycleTerm (
		.FCLK(FCLK), .rst(rst), .asN(asN), .sel(sel),
		.ramReady(ramReady), .ioReady(ioReady), .ioFault(ioFault),
		.busActive(busActive), .busActiveR(),
		.dtackN(dtackN), .vpaN(vpaN), .berrN(berrN)
	);

	addrDecode i_addrDecode (
		.FCLK(FCLK), .rst(rst), .fsb(fsb), .fcIack(fcIack),
		.busActive(busActive), .asN(asN), .sel(sel)
	);

	refreshTimer #(
		.REFRESH_PERIOD(REFRESH_PERIOD),
		.REFRESH_URGENT(REFRESH_URGENT)
	) i_refreshTimer (
		.FCLK(FCLK), .rst(rst), .refAck(refAck), .refReq(refReq), .refUrg(refUrg)
	);

	ramCtrl i_ramCtrl (
		.FCLK(FCLK), .rst(rst), .fsb(fsb), .sel(sel), .busActive(busActive),
		.asN(asN), .refReq(refReq), .refUrg(refUrg), .ramReady(ramReady),
		.refAck(refAck), .ra(ra), .rasN(rasN), .casN(casN), .lweN(lweN),
		.uweN(uweN), .oeN(oeN), .romOeN(romOeN)
	);

	ioBusSlave i_ioBusSlave (
		.FCLK(FCLK), .rst(rst), .fsb(fsb), .sel(sel), .busActive(busActive),
		.asN(asN), .ioBusy(ioBusy), .ioDone(ioDone), .ioErr(ioErr),
		.ioReq(ioReq), .ioStart(ioStart), .ioReady(ioReady), .ioFault(ioFault)
	);

	ioBusMaster i_ioBusMaster (
		.FCLK(FCLK), .rst(rst), .ioReq(ioReq), .ioStart(ioStart),
		.hostDtackN(hostDtackN), .hostBerrN(hostBerrN), .hostAddr(hostAddr),
		.hostAsN(hostAsN), .hostUdsN(hostUdsN), .hostLdsN(hostLdsN),
		.ioBusy(ioBusy), .ioDone(ioDone), .ioErr(ioErr)
	);

endmodule

`default_nettype wire

// ==== warpSE_sva.sv ====
`default_nettype none

module warpSE_sva (
	input logic FCLK,
	input logic rst,
	input logic rasN,
	input logic casN,
	input logic dtackN,
	input logic vpaN,
	input logic berrN,
	input logic hostAsN,
	input logic ioBusy,
	input logic ioStart
);
	timeunit 1ns;
	timeprecision 100ps;

	// a CPU access drops RAS before CAS and a CBR refresh drops CAS before RAS
	rasCasApart: assert property (@(posedge FCLK) disable iff (rst)
		!($fell(rasN) && $fell(casN)))
		else $error("rasN and casN fell on the same edge");

	// the CPU sees at most one termination at a time
	oneTermination: assert property (@(posedge FCLK) disable iff (rst)
		$countones({!dtackN, !vpaN, !berrN}) <= 1)
		else $error("more than one of dtackN, vpaN and berrN low");

	// a host cycle starts only from a request the busy master took two cycles before
	hostAsOnlyBusy: assert property (@(posedge FCLK) disable iff (rst)
		$fell(hostAsN) |-> ioBusy && $past(ioStart, 2))
		else $error("hostAsN fell without a request taken two cycles before");

endmodule

`default_nettype wire

// ==== tb.sv ====
`default_nettype none

module tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ROM_WAIT = warpPkg::DEF_ROM_WAIT;
	localparam int REF_PERIOD = warpPkg::DEF_REFRESH_PERIOD;
	localparam int REF_URGENT = warpPkg::DEF_REFRESH_URGENT;
	localparam int CLK_NS = 4;
	localparam int RESET_CYCLES = 16;
	localparam int NRAM = 48;
	localparam int NFIXED = 10;
	localparam int IDLE_CYCLES = 3 * REF_PERIOD;
	// every transaction is allowed the worst case of 40 cycles
	localparam int LIMIT_NS = ((NRAM + NFIXED) * 40 + IDLE_CYCLES + RESET_CYCLES) * CLK_NS;

	logic FCLK, rst, asN, udsN, ldsN, weN, fcIack, dtackN, vpaN, berrN;
	logic rasN, casN, lweN, uweN, oeN, romOeN;
	logic hostAsN, hostUdsN, hostLdsN, hostDtackN, hostBerrN;
	warpPkg::fsbAddr_t addr, hostAddr;
	warpPkg::dramAddr_t ra;

	integer seed = 75;
	int mismatches = 0;
	int failures = 0;
	// host requests the CPU has issued and the host bus has not shown yet
	warpPkg::ioReq_t ioExpQ[$];
	int ioPushed = 0;
	int hostDoneCnt = 0;
	// expected DRAM side of the FSB cycle in flight
	logic ramCycle = 1'b0;
	warpPkg::fsbCycle_t expFsb;
	warpPkg::dramAddr_t expRow, expCol;
	logic prevRas = 1'b1;
	logic prevCas = 1'b1;
	time lastRef = 0;
	logic busSeen = 1'b0;

	always #(CLK_NS / 2) FCLK = !FCLK;

	warpSE #(
		.ROM_WAIT(ROM_WAIT), .REFRESH_PERIOD(REF_PERIOD), .REFRESH_URGENT(REF_URGENT)
	) i_warpSE (
		.FCLK(FCLK), .rst(rst), .addr(addr), .asN(asN), .udsN(udsN), .ldsN(ldsN), .weN(weN),
		.fcIack(fcIack), .dtackN(dtackN), .vpaN(vpaN), .berrN(berrN), .ra(ra), .rasN(rasN),
		.casN(casN), .lweN(lweN), .uweN(uweN), .oeN(oeN), .romOeN(romOeN), .hostAddr(hostAddr),
		.hostAsN(hostAsN), .hostUdsN(hostUdsN), .hostLdsN(hostLdsN),
		.hostDtackN(hostDtackN), .hostBerrN(hostBerrN)
	);

	bind warpSE warpSE_sva i_warpSE_sva (
		.FCLK(FCLK), .rst(rst), .rasN(rasN), .casN(casN), .dtackN(dtackN), .vpaN(vpaN),
		.berrN(berrN), .hostAsN(hostAsN), .ioBusy(ioBusy), .ioStart(ioStart)
	);

	// the host answers these addresses with a bus error
	function automatic logic isFaulting(input warpPkg::fsbAddr_t a);
		return a[23:20] == 4'hE;
	endfunction

	// termination is given as the pin levels {dtackN, vpaN, berrN}
	function automatic void expectTerm(input warpPkg::fsbCycle_t c, input logic iack,
			output warpPkg::devSel_e sel, output logic [2:0] term,
			output warpPkg::dramAddr_t row, output warpPkg::dramAddr_t col,
			output warpPkg::ioReq_t req);
		if (iack) sel = warpPkg::selIack;
		else if (c.addr[23:22] == 2'b00) sel = warpPkg::selRam;
		else if (c.addr[23:20] == 4'h4) sel = warpPkg::selRom;
		else if (c.addr[23:20] == 4'h5 || c.addr[23:20] >= 4'hC) sel = warpPkg::selIo;
		else sel = warpPkg::selNone;
		case (sel)
			warpPkg::selIack: term = 3'b101;
			warpPkg::selNone: term = 3'b110;
			// a bus error reaches the CPU only on reads because posted writes lose it
			warpPkg::selIo:   term = (!c.write && isFaulting(c.addr)) ? 3'b110 : 3'b011;
			default:          term = 3'b011;
		endcase
		row = {2'b00, c.addr[21:12]};
		col = {1'b0, c.addr[11:1]};
		req = '{write: c.write, upper: c.upper, lower: c.lower, addr: c.addr};
	endfunction

	task automatic reportFailure(input string msg);
		failures++;
		$display("FAIL at %0t: %s", $time, msg);
	endtask

	task automatic checkSel(input warpPkg::devSel_e exp, input warpPkg::devSel_e act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: sel expected %s got %s",
				$time, exp.name(), act.name());
		end
	endtask

	task automatic checkTerm(input logic [2:0] exp, input logic [2:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: {dtackN,vpaN,berrN} expected %b got %b",
				$time, exp, act);
		end
	endtask

	task automatic checkDram(input string name, input warpPkg::dramAddr_t exp,
			input warpPkg::dramAddr_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic checkStrobe(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic checkIoReq(input warpPkg::ioReq_t exp, input warpPkg::ioReq_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH at %0t: ioReq expected %h got %h", $time, exp, act);
		end
	endtask

	// an idle bus gets its refresh right after the period while traffic may push it to urgent
	task automatic checkRefreshGap(input logic restart);
		int gap;
		int limit;
		gap = int'(($time - lastRef) / CLK_NS);
		limit = busSeen ? REF_PERIOD + REF_URGENT + 8 : REF_PERIOD + 4;
		if (gap > limit) begin
			reportFailure($sformatf("no refresh for %0d cycles, limit %0d", gap, limit));
		end
		if (restart) begin
			lastRef = $time;
			busSeen = !asN;
		end
	endtask

	task automatic busCycle(input warpPkg::fsbAddr_t a, input logic write, upper, lower, iack);
		warpPkg::devSel_e sel;
		warpPkg::ioReq_t req;
		logic [2:0] term;
		logic [2:0] seen;
		int k;
		expFsb = '{addr: a, write: write, upper: upper, lower: lower};
		expectTerm(expFsb, iack, sel, term, expRow, expCol, req);
		ramCycle = (sel == warpPkg::selRam);
		if (sel == warpPkg::selIo) begin
			ioExpQ.push_back(req);
			ioPushed++;
		end
		@(posedge FCLK);
		addr <= a;
		weN <= !write;
		udsN <= !upper;
		ldsN <= !lower;
		fcIack <= iack;
		asN <= 1'b0;
		// k counts edges since AS fell and the select is valid from edge 2 on
		k = 0;
		forever begin
			@(negedge FCLK);
			seen = {dtackN, vpaN, berrN};
			if (seen != 3'b111) break;
			@(posedge FCLK);
			k++;
		end
		checkTerm(term, seen);
		checkSel(sel, i_warpSE.sel);
		checkStrobe("romOeN", !(sel == warpPkg::selRom && !write), romOeN);
		if (sel == warpPkg::selRom && k - 2 != ROM_WAIT)
			reportFailure($sformatf("ROM DTACK came %0d cycles after select", k - 2));
		// reads wait for their host cycle while posted writes finish before theirs
		if (sel == warpPkg::selIo && hostDoneCnt != (write ? ioPushed - 1 : ioPushed))
			reportFailure("I/O cycle ended at the wrong point of its host cycle");
		@(posedge FCLK);
		asN <= 1'b1;
		udsN <= 1'b1;
		ldsN <= 1'b1;
		weN <= 1'b1;
		fcIack <= 1'b0;
		ramCycle = 1'b0;
		repeat (2) @(posedge FCLK);
	endtask

	task automatic fsbRead(input warpPkg::fsbAddr_t a, input logic upper, lower,
			input logic iack = 1'b0);
		busCycle(a, 1'b0, upper, lower, iack);
	endtask

	task automatic fsbWrite(input warpPkg::fsbAddr_t a, input logic upper, lower);
		busCycle(a, 1'b1, upper, lower, 1'b0);
	endtask

	// CPU row and column strobes are checked against the cycle and CBR refresh for its spacing
	always @(negedge FCLK) begin
		if (rst) begin
			lastRef = $time;
			busSeen = 1'b0;
		end else begin
			if (!asN) busSeen = 1'b1;
			if (prevRas && !rasN && casN) begin
				if (!ramCycle) reportFailure("DRAM row strobe outside a RAM cycle");
				else checkDram("ra row", expRow, ra);
			end
			if (prevCas && !casN && !rasN) begin
				checkDram("ra column", expCol, ra);
				checkStrobe("lweN", !(expFsb.write && expFsb.lower), lweN);
				checkStrobe("uweN", !(expFsb.write && expFsb.upper), uweN);
				checkStrobe("oeN", expFsb.write, oeN);
			end
			if (prevCas && !casN && rasN) checkRefreshGap(1'b1);
		end
		prevRas = rasN;
		prevCas = casN;
	end

	// host device model with a random DTACK delay
	initial begin : hostModel
		warpPkg::ioReq_t actReq;
		logic fault;
		int delay;
		forever begin
			@(negedge FCLK);
			if (!rst && !hostAsN) begin
				actReq = '{write: i_warpSE.ioReq.write, upper: !hostUdsN, lower: !hostLdsN,
					addr: hostAddr};
				if (ioExpQ.size() == 0) begin
					reportFailure("host cycle without a pending I/O request");
				end else begin
					checkIoReq(ioExpQ.pop_front(), actReq);
				end
				fault = isFaulting(hostAddr);
				delay = 1 + ($unsigned($random(seed)) % 8);
				repeat (delay) @(posedge FCLK);
				if (fault) hostBerrN <= 1'b0;
				else hostDtackN <= 1'b0;
				do @(negedge FCLK); while (!hostAsN);
				hostDoneCnt++;
				@(posedge FCLK);
				hostDtackN <= 1'b1;
				hostBerrN <= 1'b1;
			end
		end
	end

	initial begin : watchdog
		#(LIMIT_NS);
		$display("timeout after %0d ns, a bus cycle never terminated", LIMIT_NS);
		$display("sim failed");
		$finish;
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [1:0] lanes;
		FCLK = 1'b0;
		rst = 1'b1;
		addr = '0;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		weN = 1'b1;
		fcIack = 1'b0;
		hostDtackN = 1'b1;
		hostBerrN = 1'b1;
		repeat (RESET_CYCLES) @(posedge FCLK);
		rst <= 1'b0;
		repeat (2) @(posedge FCLK);
		// continuous RAM traffic spans several refresh intervals
		for (int i = 0; i < NRAM; i++) begin
			rnd = $random(seed);
			lanes = rnd[23:22];
			if (lanes == 2'b00) lanes = 2'b11;
			if (rnd[31]) fsbWrite({2'b00, rnd[20:0]}, lanes[1], lanes[0]);
			else fsbRead({2'b00, rnd[20:0]}, lanes[1], lanes[0]);
		end
		fsbRead({4'h4, 19'h00010}, 1'b1, 1'b1);
		fsbRead({4'h4, 19'h3FFFF}, 1'b1, 1'b0);
		fsbWrite({4'h4, 19'h00020}, 1'b1, 1'b1);
		fsbRead({4'h5, 19'h00100}, 1'b1, 1'b1);
		fsbRead({4'hE, 19'h00200}, 1'b0, 1'b1);
		// back-to-back writes so the second can find the master still busy with the first
		fsbWrite({4'hC, 19'h01000}, 1'b1, 1'b1);
		fsbWrite({4'hD, 19'h02000}, 1'b1, 1'b0);
		fsbWrite({4'hE, 19'h03000}, 1'b0, 1'b1);
		fsbRead({4'h8, 19'h00000}, 1'b1, 1'b1);
		fsbRead(23'h7FFFFF, 1'b1, 1'b1, 1'b1);
		// idle bus so only refresh runs
		repeat (IDLE_CYCLES) @(posedge FCLK);
		@(negedge FCLK);
		checkRefreshGap(1'b0);
		if (ioExpQ.size() != 0) reportFailure("I/O requests never reached the host bus");
		$display("errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
warpPkg.sv
addrDecode.sv
refreshTimer.sv
ramCtrl.sv
ioBusSlave.sv
ioBusMaster.sv
cycleTerm.sv
warpSE.sv
warpSE_sva.sv
tb.sv
